/* compile.f */
rtl/wb_pkg.sv
rtl/register_file.sv
rtl/cp0_registers.sv
rtl/wb_stage.sv
rtl/wb_top.sv
bench/wb_assertions.sv
bench/wb_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build with verilator, run, and decide on the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module wb_tb -f compile.f -o wb_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/wb_sim +verilator+error+limit+1000 > sim.log 2>&1 ; cat sim.log

grep -qx "Finished with no errors" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* bench/wb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_tb;
  import wb_pkg::*;

  localparam int cycle_limit = 2000;
  localparam int item_width = 92;

  logic clock;
  logic reset;
  logic in_valid;
  logic in_ready;
  logic [data_width-1:0] in_pc;
  logic [data_width-1:0] in_result;
  logic in_write_enable;
  logic [reg_addr_width-1:0] in_write_address;
  logic [strobe_width-1:0] in_write_strobe;
  logic in_move_from_cp0;
  logic in_move_to_cp0;
  logic [reg_addr_width-1:0] in_cp0_address;
  logic [2:0] in_cp0_select;
  logic in_exception;
  logic [exc_code_width-1:0] in_exc_code;
  logic in_delay_slot;
  logic in_eret;
  logic commit_valid;
  logic commit_ready;
  logic [data_width-1:0] commit_pc;
  logic [strobe_width-1:0] commit_write_strobe;
  logic [reg_addr_width-1:0] commit_write_address;
  logic [data_width-1:0] commit_write_data;
  logic flush;
  logic [data_width-1:0] flush_pc;
  logic [reg_addr_width-1:0] read_address_a;
  logic [data_width-1:0] read_data_a;
  logic [reg_addr_width-1:0] read_address_b;
  logic [data_width-1:0] read_data_b;

  integer seed;
  int cycle_count = 0;
  int error_count = 0;
  int check_count = 0;
  int test_number = 1;
  int test_errors_start = 0;
  int total_errors;
  logic ready_random;
  logic next_ready;
  logic [data_width-1:0] next_pc;
  logic [reg_addr_width-1:0] fired_address;

  // model of the architectural state
  logic [data_width-1:0] model_regs [32];
  logic [31:0] model_known;
  status_word model_status;
  logic [data_width-1:0] model_cause;
  logic [data_width-1:0] model_epc;
  logic [item_width-1:0] pending [$];

  wb_top dut_i (
    .clock(clock), .reset(reset), .in_valid(in_valid), .in_ready(in_ready),
    .in_pc(in_pc), .in_result(in_result), .in_write_enable(in_write_enable),
    .in_write_address(in_write_address), .in_write_strobe(in_write_strobe),
    .in_move_from_cp0(in_move_from_cp0), .in_move_to_cp0(in_move_to_cp0),
    .in_cp0_address(in_cp0_address), .in_cp0_select(in_cp0_select),
    .in_exception(in_exception), .in_exc_code(in_exc_code),
    .in_delay_slot(in_delay_slot), .in_eret(in_eret),
    .commit_valid(commit_valid), .commit_ready(commit_ready), .commit_pc(commit_pc),
    .commit_write_strobe(commit_write_strobe), .commit_write_address(commit_write_address),
    .commit_write_data(commit_write_data), .flush(flush), .flush_pc(flush_pc),
    .read_address_a(read_address_a), .read_data_a(read_data_a),
    .read_address_b(read_address_b), .read_data_b(read_data_b)
  );

  bind wb_stage wb_assertions assertions_i (
    .clock(clock), .reset(reset), .in_valid(in_valid), .in_ready(in_ready),
    .in_exception(in_exception), .in_eret(in_eret), .commit_valid(commit_valid),
    .commit_ready(commit_ready), .commit_pc(commit_pc),
    .commit_write_strobe(commit_write_strobe), .commit_write_address(commit_write_address),
    .commit_write_data(commit_write_data), .rf_write_enable(rf_write_enable),
    .flush(flush)
  );

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("run stopped after %0d cycles before the tests completed", cycle_count);
      $display("Finished with errors");
      $finish;
    end
  end

  // ready is drawn on the falling edge, applied after the rising one
  always @(negedge clock) begin
    next_ready = ready_random ? 1'($random(seed)) : 1'b1;
  end

  always @(posedge clock) begin
    #1;
    commit_ready = next_ready;
  end

  // port a looks at the register the last commit targeted
  always @(posedge clock) begin
    #1;
    read_address_a = fired_address;
  end

  task automatic check_value(input string name, input logic [31:0] got,
      input logic [31:0] expected);
    check_count++;
    assert (got === expected) else begin
      $display("ERROR %s got %h expected %h", name, got, expected);
      error_count++;
    end
  endtask

  function automatic logic [31:0] model_read(input logic [4:0] address);
    return (address == 5'd0) ? 32'h0 : model_regs[address];
  endfunction

  function automatic logic [31:0] model_cp0_read(input logic [4:0] address,
      input logic [2:0] select);
    if (select != 3'd0) begin
      return 32'h0;
    end
    case (address)
      cp0_reg_status: return model_status.raw;
      cp0_reg_cause: return model_cause;
      cp0_reg_epc: return model_epc;
      default: return 32'h0;
    endcase
  endfunction

  // expected commit record and flush, then the model takes the item's effects
  function automatic void predict_commit(input logic [item_width-1:0] item,
      output logic [31:0] pc, output logic [3:0] strobe_out, output logic [4:0] address_out,
      output logic [31:0] data, output logic flush_out, output logic [31:0] flush_pc_out);
    logic [31:0] result;
    logic we;
    logic [4:0] waddr;
    logic [3:0] strobe;
    logic mfc0;
    logic mtc0;
    logic [4:0] cp0_address;
    logic [2:0] cp0_select;
    logic exc;
    logic [4:0] code;
    logic ds;
    logic eret;
    {pc, result, we, waddr, strobe, mfc0, mtc0, cp0_address, cp0_select, exc, code, ds,
     eret} = item;
    data = mfc0 ? model_cp0_read(cp0_address, cp0_select) : result;
    strobe_out = (we && !exc) ? strobe : 4'h0;
    address_out = waddr;
    flush_out = exc || eret;
    flush_pc_out = exc ? exception_vector : model_epc;
    for (int i = 0; i < 4; i++) begin
      if (strobe_out[i]) begin
        model_regs[waddr][i*8 +: 8] = data[i*8 +: 8];
      end
    end
    if (strobe_out == 4'hf) begin
      model_known[waddr] = 1'b1;
    end
    if (exc) begin
      model_cause[6:2] = code;
      if (!model_status.fields.exl) begin
        model_status.fields.exl = 1'b1;
        model_cause[31] = ds;
        model_epc = ds ? pc - 32'd4 : pc;
      end
    end else if (eret) begin
      model_status.fields.exl = 1'b0;
    end else if (mtc0 && cp0_select == 3'd0) begin
      case (cp0_address)
        cp0_reg_status: model_status.raw = (model_status.raw & ~status_writable_mask)
                                         | (result & status_writable_mask);
        cp0_reg_cause: model_cause[9:8] = result[9:8];
        cp0_reg_epc: model_epc = result;
        default: begin
        end
      endcase
    end
  endfunction

  always @(negedge clock) begin
    logic [31:0] exp_pc;
    logic [3:0] exp_strobe;
    logic [4:0] exp_address;
    logic [31:0] exp_data;
    logic exp_flush;
    logic [31:0] exp_flush_pc;
    logic redirect;
    if (!reset) begin
      redirect = 1'b0;
      if (model_known[read_address_a]) begin
        check_value("read_data_a", read_data_a, model_read(read_address_a));
      end
      if (model_known[read_address_b]) begin
        check_value("read_data_b", read_data_b, model_read(read_address_b));
      end
      if (commit_valid && commit_ready) begin
        assert (pending.size() != 0) else begin
          $display("an instruction committed that was never accepted or was dropped");
          error_count++;
        end
        if (pending.size() != 0) begin
          predict_commit(pending.pop_front(), exp_pc, exp_strobe, exp_address, exp_data,
                         exp_flush, exp_flush_pc);
          check_value("commit_pc", commit_pc, exp_pc);
          check_value("commit_write_strobe", 32'(commit_write_strobe), 32'(exp_strobe));
          check_value("commit_write_address", 32'(commit_write_address), 32'(exp_address));
          check_value("commit_write_data", commit_write_data, exp_data);
          check_value("flush", 32'(flush), 32'(exp_flush));
          if (exp_flush) begin
            check_value("flush_pc", flush_pc, exp_flush_pc);
          end
          redirect = exp_flush;
          fired_address = exp_address;
        end
      end else begin
        check_value("commit_valid", 32'(commit_valid), 32'(pending.size() != 0));
        check_value("flush", 32'(flush), 32'h0);
      end
      // input offered alongside a redirect is discarded
      if (in_valid && in_ready && !redirect) begin
        pending.push_back({in_pc, in_result, in_write_enable, in_write_address,
                           in_write_strobe, in_move_from_cp0, in_move_to_cp0, in_cp0_address,
                           in_cp0_select, in_exception, in_exc_code, in_delay_slot, in_eret});
      end
    end
  end

  task automatic send_item(input logic write_enable, input logic [4:0] write_address,
      input logic [3:0] write_strobe, input logic [31:0] result, input logic move_from_cp0,
      input logic move_to_cp0, input logic [4:0] cp0_address, input logic [2:0] cp0_select,
      input logic exception, input logic delay_slot, input logic eret);
    logic accepted;
    in_pc = next_pc;
    next_pc = next_pc + 32'd4;
    in_result = result;
    in_write_enable = write_enable;
    in_write_address = write_address;
    in_write_strobe = write_strobe;
    in_move_from_cp0 = move_from_cp0;
    in_move_to_cp0 = move_to_cp0;
    in_cp0_address = cp0_address;
    in_cp0_select = cp0_select;
    in_exception = exception;
    in_exc_code = 5'($random(seed));
    in_delay_slot = delay_slot;
    in_eret = eret;
    read_address_b = 5'($random(seed));
    in_valid = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clock);
      accepted = in_ready;
      @(posedge clock);
    end
    #1;
    in_valid = 1'b0;
  endtask

  task automatic send_write(input logic [4:0] address, input logic [3:0] strobe,
      input logic [31:0] data);
    send_item(1'b1, address, strobe, data, 1'b0, 1'b0, 5'd0, 3'd0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic send_cp0_read(input logic [4:0] cp0_address, input logic [2:0] cp0_select,
      input logic [4:0] destination);
    send_item(1'b1, destination, 4'hf, $random(seed), 1'b1, 1'b0, cp0_address, cp0_select,
              1'b0, 1'b0, 1'b0);
  endtask

  task automatic send_cp0_write(input logic [4:0] cp0_address, input logic [2:0] cp0_select,
      input logic [31:0] data);
    send_item(1'b0, 5'd0, 4'h0, data, 1'b0, 1'b1, cp0_address, cp0_select,
              1'b0, 1'b0, 1'b0);
  endtask

  task automatic send_exception(input logic delay_slot);
    send_item(1'b1, 5'd3, 4'hf, $random(seed), 1'b0, 1'b0, 5'd0, 3'd0,
              1'b1, delay_slot, 1'b0);
  endtask

  task automatic send_eret();
    send_item(1'b0, 5'd0, 4'h0, 32'h0, 1'b0, 1'b0, 5'd0, 3'd0, 1'b0, 1'b0, 1'b1);
  endtask

  task automatic wait_idle();
    do begin
      @(negedge clock);
    end while (pending.size() != 0 || commit_valid);
    @(posedge clock);
    #1;
  endtask

  task automatic finish_test(input string name);
    wait_idle();
    $display("test %0d %s: %0d errors", test_number, name, error_count - test_errors_start);
    test_number++;
    test_errors_start = error_count;
  endtask

  initial begin
    seed = 33;
    clock = 1'b0;
    reset = 1'b1;
    in_valid = 1'b0;
    in_pc = '0;
    in_result = '0;
    in_write_enable = 1'b0;
    in_write_address = '0;
    in_write_strobe = '0;
    in_move_from_cp0 = 1'b0;
    in_move_to_cp0 = 1'b0;
    in_cp0_address = '0;
    in_cp0_select = '0;
    in_exception = 1'b0;
    in_exc_code = '0;
    in_delay_slot = 1'b0;
    in_eret = 1'b0;
    commit_ready = 1'b1;
    read_address_a = '0;
    read_address_b = '0;
    fired_address = '0;
    ready_random = 1'b0;
    next_ready = 1'b1;
    next_pc = 32'h0040_0000;
    model_known = 32'h1;
    model_status.raw = '0;
    model_status.fields.bev = 1'b1;
    model_cause = '0;
    model_epc = '0;
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;

    // fill every register, then random strobed writes
    for (int r = 1; r < 32; r++) begin
      send_write(5'(r), 4'hf, $random(seed));
    end
    for (int n = 0; n < 40; n++) begin
      send_item(1'($random(seed)), 5'($random(seed)), 4'($random(seed)), $random(seed),
                1'b0, 1'b0, 5'd0, 3'd0, 1'b0, 1'b0, 1'b0);
    end
    finish_test("random strobed writes");

    repeat (4) send_write(5'd0, 4'($random(seed)), $random(seed));
    finish_test("writes to r0");

    ready_random = 1'b1;
    for (int n = 0; n < 40; n++) begin
      send_item(1'($random(seed)), 5'($random(seed)), 4'($random(seed)), $random(seed),
                1'b0, 1'b0, 5'd0, 3'd0, 1'b0, 1'b0, 1'b0);
    end
    ready_random = 1'b0;
    finish_test("back-pressure");

    // each exception is followed by a write offered in its flush cycle
    send_exception(1'b0);
    send_write(5'd3, 4'hf, 32'hdead_beef);
    wait_idle();
    send_cp0_read(cp0_reg_epc, 3'd0, 5'd4);
    send_cp0_read(cp0_reg_cause, 3'd0, 5'd5);
    send_cp0_read(cp0_reg_status, 3'd0, 5'd6);
    send_eret();
    wait_idle();
    send_exception(1'b1);
    send_write(5'd3, 4'hf, 32'hfeed_f00d);
    wait_idle();
    send_cp0_read(cp0_reg_epc, 3'd0, 5'd4);
    send_cp0_read(cp0_reg_cause, 3'd0, 5'd5);
    send_cp0_read(cp0_reg_status, 3'd0, 5'd6);
    finish_test("exceptions");

    send_eret();
    send_write(5'd7, 4'hf, 32'h0bad_cafe);
    wait_idle();
    send_cp0_read(cp0_reg_status, 3'd0, 5'd8);
    finish_test("eret");

    repeat (3) begin
      send_cp0_write(cp0_reg_status, 3'd0, $random(seed));
      send_cp0_write(cp0_reg_cause, 3'd0, $random(seed));
      send_cp0_write(cp0_reg_epc, 3'd0, $random(seed));
      send_cp0_write(5'd20, 3'd0, $random(seed));
      send_cp0_write(cp0_reg_status, 3'd1, $random(seed));
      send_cp0_read(cp0_reg_status, 3'd0, 5'd9);
      send_cp0_read(cp0_reg_cause, 3'd0, 5'd10);
      send_cp0_read(cp0_reg_epc, 3'd0, 5'd11);
      send_cp0_read(5'd20, 3'd0, 5'd12);
      send_cp0_read(cp0_reg_status, 3'd1, 5'd13);
    end
    finish_test("mtc0 and mfc0");

    total_errors = error_count + dut_i.wb_stage_i.assertions_i.failure_count;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", test_number - 1,
             check_count, error_count, dut_i.wb_stage_i.assertions_i.failure_count);
    if (total_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/wb_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_assertions (
  input wire clock,
  input wire reset,
  input wire in_valid,
  input wire in_ready,
  input wire in_exception,
  input wire in_eret,
  input wire commit_valid,
  input wire commit_ready,
  input wire [wb_pkg::data_width-1:0] commit_pc,
  input wire [wb_pkg::strobe_width-1:0] commit_write_strobe,
  input wire [wb_pkg::reg_addr_width-1:0] commit_write_address,
  input wire [wb_pkg::data_width-1:0] commit_write_data,
  input wire rf_write_enable,
  input wire flush
);
  logic fire;
  logic stalled;
  logic redirect_held;
  int failure_count = 0;

  assign fire = commit_valid && commit_ready;
  assign stalled = commit_valid && !commit_ready;

  // redirect flags of the accepted item, seen from the input side
  always_ff @(posedge clock) begin
    if (reset) begin
      redirect_held <= 1'b0;
    end else if (in_valid && in_ready) begin
      redirect_held <= in_exception || in_eret;
    end
  end

  // held record must not move while the trace consumer stalls
  record_stable: assert property (@(posedge clock) disable iff (reset)
    stalled |=> commit_valid && $stable(commit_pc) && $stable(commit_write_strobe)
      && $stable(commit_write_address) && $stable(commit_write_data))
  else begin
    $error("commit record changed while stalled");
    failure_count++;
  end

  no_accept_when_stalled: assert property (@(posedge clock) disable iff (reset)
    stalled |-> !in_ready)
  else begin
    $error("in_ready high during back-pressure");
    failure_count++;
  end

  write_only_on_fire: assert property (@(posedge clock) disable iff (reset)
    rf_write_enable |-> fire)
  else begin
    $error("register write without fire");
    failure_count++;
  end

  // redirect only when an exception or eret leaves the stage
  flush_only_on_redirect: assert property (@(posedge clock) disable iff (reset)
    flush |-> fire && redirect_held)
  else begin
    $error("flush without exception or eret fire");
    failure_count++;
  end

endmodule

`default_nettype wire

/* rtl/wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_top (
  input wire clock,
  input wire reset,
  input wire in_valid,
  output logic in_ready,
  input wire [wb_pkg::data_width-1:0] in_pc,
  input wire [wb_pkg::data_width-1:0] in_result,
  input wire in_write_enable,
  input wire [wb_pkg::reg_addr_width-1:0] in_write_address,
  input wire [wb_pkg::strobe_width-1:0] in_write_strobe,
  input wire in_move_from_cp0,
  input wire in_move_to_cp0,
  input wire [wb_pkg::reg_addr_width-1:0] in_cp0_address,
  input wire [2:0] in_cp0_select,
  input wire in_exception,
  input wire [wb_pkg::exc_code_width-1:0] in_exc_code,
  input wire in_delay_slot,
  input wire in_eret,
  output logic commit_valid,
  input wire commit_ready,
  output logic [wb_pkg::data_width-1:0] commit_pc,
  output logic [wb_pkg::strobe_width-1:0] commit_write_strobe,
  output logic [wb_pkg::reg_addr_width-1:0] commit_write_address,
  output logic [wb_pkg::data_width-1:0] commit_write_data,
  output logic flush,
  output logic [wb_pkg::data_width-1:0] flush_pc,
  input wire [wb_pkg::reg_addr_width-1:0] read_address_a,
  output logic [wb_pkg::data_width-1:0] read_data_a,
  input wire [wb_pkg::reg_addr_width-1:0] read_address_b,
  output logic [wb_pkg::data_width-1:0] read_data_b
);
  import wb_pkg::*;

  logic rf_write_enable;
  logic [reg_addr_width-1:0] rf_write_address;
  logic [strobe_width-1:0] rf_write_strobe;
  logic [data_width-1:0] rf_write_data;

  logic cp0_write_enable;
  logic [reg_addr_width-1:0] cp0_address;
  logic [2:0] cp0_select;
  logic [data_width-1:0] cp0_write_data;
  logic cp0_exception;
  logic cp0_eret;
  logic [data_width-1:0] cp0_exception_pc;
  logic cp0_delay_slot;
  logic [exc_code_width-1:0] cp0_exc_code;
  logic [data_width-1:0] cp0_read_data;
  logic [data_width-1:0] epc;

  wb_stage wb_stage_i (
    .clock(clock),
    .reset(reset),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_pc(in_pc),
    .in_result(in_result),
    .in_write_enable(in_write_enable),
    .in_write_address(in_write_address),
    .in_write_strobe(in_write_strobe),
    .in_move_from_cp0(in_move_from_cp0),
    .in_move_to_cp0(in_move_to_cp0),
    .in_cp0_address(in_cp0_address),
    .in_cp0_select(in_cp0_select),
    .in_exception(in_exception),
    .in_exc_code(in_exc_code),
    .in_delay_slot(in_delay_slot),
    .in_eret(in_eret),
    .commit_valid(commit_valid),
    .commit_ready(commit_ready),
    .commit_pc(commit_pc),
    .commit_write_strobe(commit_write_strobe),
    .commit_write_address(commit_write_address),
    .commit_write_data(commit_write_data),
    .rf_write_enable(rf_write_enable),
    .rf_write_address(rf_write_address),
    .rf_write_strobe(rf_write_strobe),
    .rf_write_data(rf_write_data),
    .cp0_write_enable(cp0_write_enable),
    .cp0_address(cp0_address),
    .cp0_select(cp0_select),
    .cp0_write_data(cp0_write_data),
    .cp0_exception(cp0_exception),
    .cp0_eret(cp0_eret),
    .cp0_exception_pc(cp0_exception_pc),
    .cp0_delay_slot(cp0_delay_slot),
    .cp0_exc_code(cp0_exc_code),
    .cp0_read_data(cp0_read_data),
    .epc(epc),
    .flush(flush),
    .flush_pc(flush_pc)
  );

  register_file register_file_i (
    .clock(clock),
    .write_enable(rf_write_enable),
    .write_address(rf_write_address),
    .write_strobe(rf_write_strobe),
    .write_data(rf_write_data),
    .read_address_a(read_address_a),
    .read_data_a(read_data_a),
    .read_address_b(read_address_b),
    .read_data_b(read_data_b)
  );

  cp0_registers cp0_registers_i (
    .clock(clock),
    .reset(reset),
    .write_enable(cp0_write_enable),
    .address(cp0_address),
    .select(cp0_select),
    .write_data(cp0_write_data),
    .exception(cp0_exception),
    .exc_code(cp0_exc_code),
    .delay_slot(cp0_delay_slot),
    .exception_pc(cp0_exception_pc),
    .eret(cp0_eret),
    .read_data(cp0_read_data),
    .epc(epc)
  );

endmodule

`default_nettype wire

/* rtl/wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
  input wire clock,
  input wire reset,
  input wire in_valid,
  output logic in_ready,
  input wire [wb_pkg::data_width-1:0] in_pc,
  input wire [wb_pkg::data_width-1:0] in_result,
  input wire in_write_enable,
  input wire [wb_pkg::reg_addr_width-1:0] in_write_address,
  input wire [wb_pkg::strobe_width-1:0] in_write_strobe,
  input wire in_move_from_cp0,
  input wire in_move_to_cp0,
  input wire [wb_pkg::reg_addr_width-1:0] in_cp0_address,
  input wire [2:0] in_cp0_select,
  input wire in_exception,
  input wire [wb_pkg::exc_code_width-1:0] in_exc_code,
  input wire in_delay_slot,
  input wire in_eret,
  output logic commit_valid,
  input wire commit_ready,
  output logic [wb_pkg::data_width-1:0] commit_pc,
  output logic [wb_pkg::strobe_width-1:0] commit_write_strobe,
  output logic [wb_pkg::reg_addr_width-1:0] commit_write_address,
  output logic [wb_pkg::data_width-1:0] commit_write_data,
  output logic rf_write_enable,
  output logic [wb_pkg::reg_addr_width-1:0] rf_write_address,
  output logic [wb_pkg::strobe_width-1:0] rf_write_strobe,
  output logic [wb_pkg::data_width-1:0] rf_write_data,
  output logic cp0_write_enable,
  output logic [wb_pkg::reg_addr_width-1:0] cp0_address,
  output logic [2:0] cp0_select,
  output logic [wb_pkg::data_width-1:0] cp0_write_data,
  output logic cp0_exception,
  output logic cp0_eret,
  output logic [wb_pkg::data_width-1:0] cp0_exception_pc,
  output logic cp0_delay_slot,
  output logic [wb_pkg::exc_code_width-1:0] cp0_exc_code,
  input wire [wb_pkg::data_width-1:0] cp0_read_data,
  input wire [wb_pkg::data_width-1:0] epc,
  output logic flush,
  output logic [wb_pkg::data_width-1:0] flush_pc
);
  import wb_pkg::*;

  logic valid;
  logic fire;
  logic redirect;
  logic reg_write;
  logic [data_width-1:0] write_data;

  logic [data_width-1:0] pc_q;
  logic [data_width-1:0] result_q;
  logic write_enable_q;
  logic [reg_addr_width-1:0] write_address_q;
  logic [strobe_width-1:0] write_strobe_q;
  logic move_from_cp0_q;
  logic move_to_cp0_q;
  logic [reg_addr_width-1:0] cp0_address_q;
  logic [2:0] cp0_select_q;
  logic exception_q;
  logic [exc_code_width-1:0] exc_code_q;
  logic delay_slot_q;
  logic eret_q;

  assign fire = valid && commit_ready;
  assign in_ready = !valid || fire;
  assign redirect = exception_q || eret_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (fire && redirect) begin
      // the item offered alongside a flush is dropped
      valid <= 1'b0;
    end else if (in_ready) begin
      valid <= in_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid && in_ready) begin
      pc_q <= in_pc;
      result_q <= in_result;
      write_enable_q <= in_write_enable;
      write_address_q <= in_write_address;
      write_strobe_q <= in_write_strobe;
      move_from_cp0_q <= in_move_from_cp0;
      move_to_cp0_q <= in_move_to_cp0;
      cp0_address_q <= in_cp0_address;
      cp0_select_q <= in_cp0_select;
      exception_q <= in_exception;
      exc_code_q <= in_exc_code;
      delay_slot_q <= in_delay_slot;
      eret_q <= in_eret;
    end
  end

  // excepting instructions never write back
  assign reg_write = write_enable_q && !exception_q;
  assign write_data = move_from_cp0_q ? cp0_read_data : result_q;

  assign commit_valid = valid;
  assign commit_pc = pc_q;
  assign commit_write_strobe = {strobe_width{reg_write}} & write_strobe_q;
  assign commit_write_address = write_address_q;
  assign commit_write_data = write_data;

  assign rf_write_enable = fire && reg_write;
  assign rf_write_address = write_address_q;
  assign rf_write_strobe = write_strobe_q;
  assign rf_write_data = write_data;

  assign cp0_write_enable = fire && move_to_cp0_q && !exception_q;
  assign cp0_address = cp0_address_q;
  assign cp0_select = cp0_select_q;
  assign cp0_write_data = result_q;
  assign cp0_exception = fire && exception_q;
  // exception wins over eret
  assign cp0_eret = fire && eret_q && !exception_q;
  assign cp0_exception_pc = pc_q;
  assign cp0_delay_slot = delay_slot_q;
  assign cp0_exc_code = exc_code_q;

  assign flush = fire && redirect;
  assign flush_pc = exception_q ? exception_vector : epc;

endmodule

`default_nettype wire

/* rtl/cp0_registers.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_registers (
  input wire clock,
  input wire reset,
  input wire write_enable,
  input wire [wb_pkg::reg_addr_width-1:0] address,
  input wire [2:0] select,
  input wire [wb_pkg::data_width-1:0] write_data,
  input wire exception,
  input wire [wb_pkg::exc_code_width-1:0] exc_code,
  input wire delay_slot,
  input wire [wb_pkg::data_width-1:0] exception_pc,
  input wire eret,
  output logic [wb_pkg::data_width-1:0] read_data,
  output logic [wb_pkg::data_width-1:0] epc
);
  import wb_pkg::*;

  status_word status;
  logic cause_bd;
  logic [1:0] cause_ip;
  logic [exc_code_width-1:0] cause_exc_code;
  logic [data_width-1:0] cause_word;

  // bd, software interrupt bits and exception code
  assign cause_word = {cause_bd, 21'b0, cause_ip, 1'b0, cause_exc_code, 2'b00};

  always_ff @(posedge clock) begin
    if (reset) begin
      status.raw <= '0;
      status.fields.bev <= 1'b1;
      cause_bd <= 1'b0;
      cause_ip <= 2'b00;
      cause_exc_code <= '0;
      epc <= '0;
    end else if (exception) begin
      cause_exc_code <= exc_code;
      // nested exception keeps epc, bd and exl
      if (!status.fields.exl) begin
        status.fields.exl <= 1'b1;
        cause_bd <= delay_slot;
        epc <= delay_slot ? exception_pc - 4 : exception_pc;
      end
    end else if (eret) begin
      status.fields.exl <= 1'b0;
    end else if (write_enable && select == 3'd0) begin
      case (address)
        cp0_reg_status: begin
          status.raw <= (status.raw & ~status_writable_mask)
                      | (write_data & status_writable_mask);
        end
        cp0_reg_cause: begin
          cause_ip <= write_data[9:8];
        end
        cp0_reg_epc: begin
          epc <= write_data;
        end
        default: begin
        end
      endcase
    end
  end

  // mfc0 read mux, zero for anything unimplemented
  always_comb begin
    read_data = '0;
    if (select == 3'd0) begin
      case (address)
        cp0_reg_status: read_data = status.raw;
        cp0_reg_cause: read_data = cause_word;
        cp0_reg_epc: read_data = epc;
        default: read_data = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input wire clock,
  input wire write_enable,
  input wire [wb_pkg::reg_addr_width-1:0] write_address,
  input wire [wb_pkg::strobe_width-1:0] write_strobe,
  input wire [wb_pkg::data_width-1:0] write_data,
  input wire [wb_pkg::reg_addr_width-1:0] read_address_a,
  output logic [wb_pkg::data_width-1:0] read_data_a,
  input wire [wb_pkg::reg_addr_width-1:0] read_address_b,
  output logic [wb_pkg::data_width-1:0] read_data_b
);
  import wb_pkg::*;

  logic [data_width-1:0] registers [2**reg_addr_width];

  // byte merge under strobe
  always_ff @(posedge clock) begin
    if (write_enable) begin
      for (int i = 0; i < strobe_width; i++) begin
        if (write_strobe[i]) begin
          registers[write_address][i*8 +: 8] <= write_data[i*8 +: 8];
        end
      end
    end
  end

  // r0 is hardwired, whatever was stored there
  always_comb begin
    if (read_address_a == '0) begin
      read_data_a = '0;
    end else begin
      read_data_a = registers[read_address_a];
    end
  end

  always_comb begin
    if (read_address_b == '0) begin
      read_data_b = '0;
    end else begin
      read_data_b = registers[read_address_b];
    end
  end

endmodule

`default_nettype wire

/* rtl/wb_pkg.sv */
`default_nettype none

package wb_pkg;

  localparam int data_width = 32;
  localparam int reg_addr_width = 5;
  localparam int strobe_width = 4;
  localparam int exc_code_width = 5;

  // cp0 register numbers, all at select 0
  localparam logic [reg_addr_width-1:0] cp0_reg_status = 5'd12;
  localparam logic [reg_addr_width-1:0] cp0_reg_cause = 5'd13;
  localparam logic [reg_addr_width-1:0] cp0_reg_epc = 5'd14;

  // single redirect target for every exception
  localparam logic [data_width-1:0] exception_vector = 32'hbfc0_0380;

  // bev, im and ie are software writable, exl belongs to hardware
  localparam logic [data_width-1:0] status_writable_mask = 32'h0040_ff01;

  typedef struct packed {
    logic [8:0] reserved_high;
    logic bev;
    logic [5:0] reserved_middle;
    logic [7:0] im;
    logic [5:0] reserved_low;
    logic exl;
    logic ie;
  } status_fields;

  // raw view for mtc0/mfc0, field view for exception and eret
  typedef union packed {
    logic [data_width-1:0] raw;
    status_fields fields;
  } status_word;

endpackage

`default_nettype wire
